// File: cpu_pkg.sv
package cpu_pkg;

    // data and address width
    localparam int xlen = 32;
    // register index width
    localparam int reg_addr_w = 5;
    // instruction rom size in words
    localparam int imem_depth = 256;

    // plain data or address word
    typedef logic [xlen-1:0] word_t;
    // register index
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // architectural a0
    localparam reg_addr_t a0_reg = 5'd10;
    // addi x0, x0, 0
    localparam word_t nop_instr = 32'h0000_0013;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_r      = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011
    } opcode_e;

    // alu operation select
    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_slt    = 3'd4,
        // lui passes the u immediate straight through
        alu_pass_b = 3'd5
    } alu_op_e;

    // immediate layout in the instruction word
    typedef enum logic [1:0] {
        imm_i = 2'd0,
        imm_b = 2'd1,
        imm_u = 2'd2
    } imm_fmt_e;

    // decoded control bundle
    typedef struct packed {
        // register file write
        logic     reg_wr_en;
        // operand b from immediate
        logic     alu_src;
        // conditional branch
        logic     branch;
        // bne when set, beq otherwise
        logic     branch_ne;
        alu_op_e  alu_op;
        imm_fmt_e imm_fmt;
    } ctrl_t;

endpackage

// File: pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pc_src,
    input  cpu_pkg::word_t       imm,
    output cpu_pkg::word_t       pc
);

    // sequential and branch candidates
    cpu_pkg::word_t pc_plus4;
    cpu_pkg::word_t pc_target;
    cpu_pkg::word_t next_pc;

    assign pc_plus4  = pc + cpu_pkg::word_t'(4);
    // b immediate already carries the zero low bit
    assign pc_target = pc + imm;
    assign next_pc   = pc_src ? pc_target : pc_plus4;

    // one instruction per cycle, no stall
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    // relies on the decoder and immediate unit never producing odd targets
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc lost word alignment: %h", pc);

endmodule

// File: instruction_memory.sv
`timescale 1ns/1ps

module instruction_memory (
    input  cpu_pkg::word_t pc,
    output cpu_pkg::word_t instr
);

    // word index from the byte address
    logic [$clog2(cpu_pkg::imem_depth)-1:0] word_idx;
    logic                                   in_range;

    // read-only program store
    cpu_pkg::word_t rom [cpu_pkg::imem_depth];

    initial begin
        $readmemh("program.hex", rom);
    end

    assign word_idx = pc[$clog2(cpu_pkg::imem_depth)+1:2];
    // any upper bit set means past the end of the rom
    assign in_range = (pc[cpu_pkg::xlen-1:2] < cpu_pkg::imem_depth);

    // combinational fetch, nop outside the rom
    assign instr = in_range ? rom[word_idx] : cpu_pkg::nop_instr;

endmodule

// File: control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  cpu_pkg::opcode_e opcode,
    input  logic [2:0]       funct3,
    input  logic             funct7_5,
    input  logic             zero,
    output cpu_pkg::ctrl_t   ctrl,
    output logic             pc_src
);

    // alu decoder result for r-type and i-type arithmetic
    cpu_pkg::alu_op_e arith_op;
    // only r-type may select sub from funct7
    logic             sub_ok;

    assign sub_ok = (opcode == cpu_pkg::op_r) && funct7_5;

    // alu decoder
    always_comb begin
        case (funct3)
            3'b000:  arith_op = sub_ok ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
            3'b010:  arith_op = cpu_pkg::alu_slt;
            3'b110:  arith_op = cpu_pkg::alu_or;
            3'b111:  arith_op = cpu_pkg::alu_and;
            // unsupported funct3 falls back to add
            default: arith_op = cpu_pkg::alu_add;
        endcase
    end

    // main decoder
    always_comb begin
        // nop defaults, nothing written, no branch
        ctrl         = '0;
        ctrl.alu_op  = cpu_pkg::alu_add;
        ctrl.imm_fmt = cpu_pkg::imm_i;
        case (opcode)
            cpu_pkg::op_r: begin
                ctrl.reg_wr_en = 1'b1;
                ctrl.alu_op    = arith_op;
            end
            cpu_pkg::op_imm: begin
                ctrl.reg_wr_en = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = arith_op;
            end
            cpu_pkg::op_lui: begin
                ctrl.reg_wr_en = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = cpu_pkg::alu_pass_b;
                ctrl.imm_fmt   = cpu_pkg::imm_u;
            end
            cpu_pkg::op_branch: begin
                // compare by subtraction, zero flag gives equality
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = funct3[0];
                ctrl.alu_op    = cpu_pkg::alu_sub;
                ctrl.imm_fmt   = cpu_pkg::imm_b;
            end
            default: begin
            end
        endcase
    end

    // beq takes on zero, bne on not zero
    assign pc_src = ctrl.branch & (zero ^ ctrl.branch_ne);

    // a branch must never also retire a register write
    always_comb begin
        assert (!(ctrl.reg_wr_en && ctrl.branch))
            else $error("branch decoded with register write");
    end

endmodule

// File: sign_exten.sv
`timescale 1ns/1ps

module sign_exten (
    input  cpu_pkg::word_t   instr,
    input  cpu_pkg::imm_fmt_e imm_fmt,
    output cpu_pkg::word_t   imm
);

    // candidate immediates
    cpu_pkg::word_t i_imm;
    cpu_pkg::word_t b_imm;
    cpu_pkg::word_t u_imm;

    // imm[11:0] in the top twelve bits
    assign i_imm = {{20{instr[31]}}, instr[31:20]};

    // scattered branch offset, bit 0 implied zero
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7],
                    instr[30:25], instr[11:8], 1'b0};

    // upper twenty bits, low twelve cleared
    assign u_imm = {instr[31:12], 12'b0};

    always_comb begin
        case (imm_fmt)
            cpu_pkg::imm_b: imm = b_imm;
            cpu_pkg::imm_u: imm = u_imm;
            // i format and the unused code
            default:        imm = i_imm;
        endcase
    end

endmodule

// File: register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::reg_addr_t ad1,
    input  cpu_pkg::reg_addr_t ad2,
    input  cpu_pkg::reg_addr_t ad3,
    input  cpu_pkg::word_t     wd3,
    input  logic               we3,
    output cpu_pkg::word_t     rd1,
    output cpu_pkg::word_t     rd2,
    output cpu_pkg::word_t     a0
);

    // x1..x31, x0 has no storage
    cpu_pkg::word_t regs [1:31];

    // synchronous write, reset has priority
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we3 && (ad3 != '0)) begin
            regs[ad3] <= wd3;
        end
    end

    // combinational reads see the pre-write value
    assign rd1 = (ad1 == '0) ? '0 : regs[ad1];
    assign rd2 = (ad2 == '0) ? '0 : regs[ad2];

    // observation tap
    assign a0 = regs[cpu_pkg::a0_reg];

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::word_t   alu_op1,
    input  cpu_pkg::word_t   alu_op2,
    input  cpu_pkg::alu_op_e alu_ctrl,
    output cpu_pkg::word_t   alu_out,
    output logic             zero
);

    // signed less-than for slt and slti
    logic lt;

    assign lt = $signed(alu_op1) < $signed(alu_op2);

    always_comb begin
        case (alu_ctrl)
            cpu_pkg::alu_add:    alu_out = alu_op1 + alu_op2;
            cpu_pkg::alu_sub:    alu_out = alu_op1 - alu_op2;
            cpu_pkg::alu_and:    alu_out = alu_op1 & alu_op2;
            cpu_pkg::alu_or:     alu_out = alu_op1 | alu_op2;
            cpu_pkg::alu_slt:    alu_out = {{(cpu_pkg::xlen-1){1'b0}}, lt};
            // lui path
            cpu_pkg::alu_pass_b: alu_out = alu_op2;
            default:             alu_out = '0;
        endcase
    end

    // equality test for branches
    assign zero = (alu_out == '0);

endmodule

// File: top.sv
`timescale 1ns/1ps

module top (
    input  logic           clk,
    input  logic           rst,
    output cpu_pkg::word_t a0
);

    // fetch
    cpu_pkg::word_t pc;
    cpu_pkg::word_t instr;

    // instruction fields
    cpu_pkg::opcode_e   opcode;
    logic [2:0]         funct3;
    logic               funct7_5;
    cpu_pkg::reg_addr_t rs1;
    cpu_pkg::reg_addr_t rs2;
    cpu_pkg::reg_addr_t rd;

    // decode
    cpu_pkg::ctrl_t ctrl;
    logic           pc_src;
    cpu_pkg::word_t imm;

    // execute
    cpu_pkg::word_t rd1;
    cpu_pkg::word_t rd2;
    cpu_pkg::word_t alu_b;
    cpu_pkg::word_t alu_out;
    logic           zero;

    pc_unit i_pc_unit (
        .clk    (clk),
        .rst    (rst),
        .pc_src (pc_src),
        .imm    (imm),
        .pc     (pc)
    );

    instruction_memory i_imem (
        .pc    (pc),
        .instr (instr)
    );

    // field slicing, unknown opcodes decode as nop downstream
    assign opcode   = cpu_pkg::opcode_e'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7_5 = instr[30];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign rd       = instr[11:7];

    control_unit i_control_unit (
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7_5 (funct7_5),
        .zero     (zero),
        .ctrl     (ctrl),
        .pc_src   (pc_src)
    );

    sign_exten i_sign_exten (
        .instr   (instr),
        .imm_fmt (ctrl.imm_fmt),
        .imm     (imm)
    );

    // write-back is always the alu result
    register_file i_register_file (
        .clk (clk),
        .rst (rst),
        .ad1 (rs1),
        .ad2 (rs2),
        .ad3 (rd),
        .wd3 (alu_out),
        .we3 (ctrl.reg_wr_en),
        .rd1 (rd1),
        .rd2 (rd2),
        .a0  (a0)
    );

    // operand b select
    assign alu_b = ctrl.alu_src ? imm : rd2;

    alu i_alu (
        .alu_op1  (rd1),
        .alu_op2  (alu_b),
        .alu_ctrl (ctrl.alu_op),
        .alu_out  (alu_out),
        .zero     (zero)
    );

endmodule

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
    input  logic           clk,
    input  logic           rst,
    input  cpu_pkg::word_t a0,
    output logic           done,
    output int             error_count,
    output int             timeout_count
);

    // reset release expected within this many cycles
    localparam int reset_limit = 100;
    // quiet window after the last expected write
    localparam int tail_cycles = 50;

    // expected a0 sequence from the cases file
    string          case_name [$];
    cpu_pkg::word_t case_value [$];
    int             case_budget [$];

    // last a0 value seen on a falling edge
    cpu_pkg::word_t last_a0;

    // lines starting with # are notes
    task automatic load_cases();
        int             fd;
        int             fields;
        string          line;
        string          name;
        cpu_pkg::word_t value;
        int             budget;
        fd = $fopen("cpu_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open cpu_cases.txt for reading");
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() <= 1 || line.substr(0, 0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %d", name, value, budget);
            if (fields == 3) begin
                case_name.push_back(name);
                case_value.push_back(value);
                case_budget.push_back(budget);
            end else begin
                $display("malformed line in cpu_cases.txt: %s", line);
                error_count++;
            end
        end
        $fclose(fd);
    endtask

    // rst read on rising edges, a0 on falling edges where it is stable
    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (rst === 1'b1 && cycles < reset_limit) begin
            @(negedge clk);
            // every reset edge so far has cleared x10
            if (a0 !== '0) begin
                $display("[FAIL] reset_a0 expected %h actual %h", 32'h0, a0);
                error_count++;
            end
            @(posedge clk);
            cycles++;
        end
        if (cycles >= reset_limit) begin
            $display("reset was not released within %0d cycles", reset_limit);
            timeout_count++;
        end
        // first instruction after release does not touch a0
        @(negedge clk);
        if (a0 !== '0) begin
            $display("[FAIL] reset_a0 expected %h actual %h", 32'h0, a0);
            error_count++;
        end
        last_a0 = a0;
    endtask

    // next change of a0 must match the next entry
    task automatic wait_for_update(input int idx);
        int cycles;
        cycles = 0;
        while (a0 === last_a0 && cycles < case_budget[idx]) begin
            @(negedge clk);
            cycles++;
        end
        if (a0 === last_a0) begin
            $display("test %s timed out waiting for an a0 update", case_name[idx]);
            timeout_count++;
        end else begin
            if (a0 !== case_value[idx]) begin
                $display("[FAIL] %s expected %h actual %h", case_name[idx],
                         case_value[idx], a0);
                error_count++;
            end
            last_a0 = a0;
        end
    endtask

    // self-branch at the end, a0 should stay put
    task automatic watch_program_end();
        int cycles;
        cycles = 0;
        while (cycles < tail_cycles) begin
            @(negedge clk);
            cycles++;
            if (a0 !== last_a0) begin
                $display("program_end: unexpected a0 write after the program end, a0 now %h",
                         a0);
                error_count++;
                last_a0 = a0;
            end
        end
    endtask

    initial begin
        done          = 1'b0;
        error_count   = 0;
        timeout_count = 0;
        load_cases();
        if (case_name.size() == 0) begin
            $display("no test cases were loaded from cpu_cases.txt");
            error_count++;
        end
        wait_reset_release();
        for (int i = 0; i < case_name.size(); i++) begin
            wait_for_update(i);
        end
        watch_program_end();
        done = 1'b1;
    end

endmodule

// File: tb_top.sv
`timescale 1ns/1ps

module tb_top;

    // bound on the whole run in clock cycles
    localparam int cycle_limit  = 2000;
    localparam int reset_cycles = 16;

    logic           clk;
    logic           rst;
    cpu_pkg::word_t a0;

    // checker status
    logic done;
    int   error_count;
    int   timeout_count;
    int   cycles;

    top i_top (
        .clk (clk),
        .rst (rst),
        .a0  (a0)
    );

    // observes the same nets as the dut
    tb_checker i_checker (
        .clk           (clk),
        .rst           (rst),
        .a0            (a0),
        .done          (done),
        .error_count   (error_count),
        .timeout_count (timeout_count)
    );

    // 8 ns period
    always #4 clk = ~clk;

    initial begin
        clk    = 1'b0;
        rst    = 1'b1;
        cycles = 0;
        // release on a falling edge
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        // done changes on falling edges, read it on rising ones
        while (done !== 1'b1 && cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            $display("run reached the limit of %0d cycles before the checker finished",
                     cycle_limit);
        end
        $display("checks complete: %0d mismatches, %0d timeouts", error_count, timeout_count);
        if (done === 1'b1 && error_count == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: cpu_cases.txt
# columns: test name, expected a0 in hex, cycle budget for that a0 update
# entries follow the order of the a0 writes in program.hex
alu_addi_neg  fffffffb  10
alu_add       000000c6  4
alu_sub       ffffffee  4
alu_and       00000048  4
alu_or        0000007e  4
alu_andi      0000000c  4
alu_ori       0000015a  4
cmp_slt       00000001  4
cmp_slti      00000000  4
lui_upper     abcde000  4
lui_addi      abcddff0  4
x0_protect    00000007  6
branch_sum    00000037  60

// File: program.hex
// one instruction word per line, starting at address 0
// operands x5 = -5, x6 = 0x6c, x7 = 0x5a
ffb00293 // 00 addi x5, x0, -5
06c00313 // 04 addi x6, x0, 0x6c
05a00393 // 08 addi x7, x0, 0x5a
ffb00513 // 0c addi x10, x0, -5
00730533 // 10 add  x10, x6, x7
40638533 // 14 sub  x10, x7, x6
00737533 // 18 and  x10, x6, x7
00736533 // 1c or   x10, x6, x7
00f37513 // 20 andi x10, x6, 0x0f
1003e513 // 24 ori  x10, x7, 0x100
0062a533 // 28 slt  x10, x5, x6
fff32513 // 2c slti x10, x6, -1
abcde537 // 30 lui  x10, 0xabcde
ff050513 // 34 addi x10, x10, -16
00730033 // 38 add  x0, x6, x7
00700513 // 3c addi x10, x0, 7
00000613 // 40 addi x12, x0, 0
00a00693 // 44 addi x13, x0, 10
00d60633 // 48 add  x12, x12, x13
fff68693 // 4c addi x13, x13, -1
fe069ce3 // 50 bne  x13, x0, -8
00000463 // 54 beq  x0, x0, +8
3e700513 // 58 addi x10, x0, 999
00060513 // 5c addi x10, x12, 0
00000063 // 60 beq  x0, x0, 0

// File: build.f
cpu_pkg.sv
pc_unit.sv
instruction_memory.sv
control_unit.sv
sign_exten.sv
register_file.sv
alu.sv
top.sv
tb_checker.sv
tb_top.sv

// File: run_sim.sh
#!/bin/sh
# run from the project root so program.hex and cpu_cases.txt resolve
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f build.f -o tb_top_sim \
    && ./obj_dir/tb_top_sim > sim.log 2>&1 \
    || echo "build or simulation stopped with an error" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
# no verdict at all is a failure too
grep -q "TEST PASS" sim.log || exit 1
exit 0
